/* project.f */
rtl/core_pkg.sv
rtl/inst_decode.sv
rtl/id_ex_reg.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/core_ex_top.sv
verif/core_ex_assert.sv
verif/tb_core_ex.sv

/* rtl/core_ex_top.sv */
`timescale 1ns/10ps

module core_ex_top import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    input  logic [31:0]       instr_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic              instr_valid_i,
    input  logic              stall_i,
    output logic              redirect_o,
    output logic [XLEN-1:0]   redirect_pc_o,
    output logic              wb_en_o,
    output logic [REG_AW-1:0] wb_addr_o,
    output logic [XLEN-1:0]   wb_data_o,
    output logic [XLEN-1:0]   wb_pc_o
);

    logic              dec_valid;
    alu_op_e           dec_alu_op;
    sel_a_e            dec_sel_a;
    sel_b_e            dec_sel_b;
    br_type_e          dec_br_type;
    logic              dec_write_rd;
    logic [XLEN-1:0]   dec_imm;
    logic [REG_AW-1:0] dec_rs1addr;
    logic [REG_AW-1:0] dec_rs2addr;
    logic [REG_AW-1:0] dec_rwaddr;

    logic              ex_valid;
    logic [XLEN-1:0]   ex_pc;
    alu_op_e           ex_alu_op;
    sel_a_e            ex_sel_a;
    sel_b_e            ex_sel_b;
    br_type_e          ex_br_type;
    logic              ex_write_rd;
    logic [XLEN-1:0]   ex_imm;
    logic [REG_AW-1:0] ex_rs1addr;
    logic [REG_AW-1:0] ex_rs2addr;
    logic [REG_AW-1:0] ex_rwaddr;

    logic [REG_AW-1:0] rf_rs1addr;
    logic [REG_AW-1:0] rf_rs2addr;
    logic [XLEN-1:0]   rf_rs1data;
    logic [XLEN-1:0]   rf_rs2data;

    inst_decode u_decode (
        .instr_i    (instr_i),
        .valid_o    (dec_valid),
        .alu_op_o   (dec_alu_op),
        .sel_a_o    (dec_sel_a),
        .sel_b_o    (dec_sel_b),
        .br_type_o  (dec_br_type),
        .write_rd_o (dec_write_rd),
        .imm_o      (dec_imm),
        .rs1addr_o  (dec_rs1addr),
        .rs2addr_o  (dec_rs2addr),
        .rwaddr_o   (dec_rwaddr)
    );

    id_ex_reg u_id_ex (
        .clk        (clk),
        .rst_i      (rst_i),
        .bubble_i   (stall_i),
        .flush_i    (redirect_o),  // taken branch drops the next fetch
        .valid_in_i (instr_valid_i),
        .legal_i    (dec_valid),
        .pc_i       (pc_i),
        .alu_op_i   (dec_alu_op),
        .sel_a_i    (dec_sel_a),
        .sel_b_i    (dec_sel_b),
        .br_type_i  (dec_br_type),
        .write_rd_i (dec_write_rd),
        .imm_i      (dec_imm),
        .rs1addr_i  (dec_rs1addr),
        .rs2addr_i  (dec_rs2addr),
        .rwaddr_i   (dec_rwaddr),
        .valid_o    (ex_valid),
        .pc_o       (ex_pc),
        .alu_op_o   (ex_alu_op),
        .sel_a_o    (ex_sel_a),
        .sel_b_o    (ex_sel_b),
        .br_type_o  (ex_br_type),
        .write_rd_o (ex_write_rd),
        .imm_o      (ex_imm),
        .rs1addr_o  (ex_rs1addr),
        .rs2addr_o  (ex_rs2addr),
        .rwaddr_o   (ex_rwaddr)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rs1addr_i (rf_rs1addr),
        .rs2addr_i (rf_rs2addr),
        .rs1data_o (rf_rs1data),
        .rs2data_o (rf_rs2data),
        .we_i      (wb_en_o),
        .waddr_i   (wb_addr_o),
        .wdata_i   (wb_data_o)
    );

    exec_unit u_exec (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .valid_i       (ex_valid),
        .pc_i          (ex_pc),
        .alu_op_i      (ex_alu_op),
        .sel_a_i       (ex_sel_a),
        .sel_b_i       (ex_sel_b),
        .br_type_i     (ex_br_type),
        .write_rd_i    (ex_write_rd),
        .imm_i         (ex_imm),
        .rs1addr_i     (ex_rs1addr),
        .rs2addr_i     (ex_rs2addr),
        .rwaddr_i      (ex_rwaddr),
        .rs1addr_o     (rf_rs1addr),
        .rs2addr_o     (rf_rs2addr),
        .rs1data_i     (rf_rs1data),
        .rs2data_i     (rf_rs2data),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_en_o       (wb_en_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .wb_pc_o       (wb_pc_o)
    );

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    localparam int XLEN   = 64;  // data and pc width
    localparam int REG_AW = 5;   // 32 architectural registers

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A_RS1,
        SEL_A_PC,
        SEL_A_ZERO
    } sel_a_e;

    typedef enum logic [1:0] {
        SEL_B_RS2,
        SEL_B_IMM,
        SEL_B_FOUR
    } sel_b_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JAL,
        BR_JALR
    } br_type_e;

endpackage

/* rtl/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              valid_i,
    input  logic [XLEN-1:0]   pc_i,
    input  alu_op_e           alu_op_i,
    input  sel_a_e            sel_a_i,
    input  sel_b_e            sel_b_i,
    input  br_type_e          br_type_i,
    input  logic              write_rd_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [REG_AW-1:0] rs1addr_i,
    input  logic [REG_AW-1:0] rs2addr_i,
    input  logic [REG_AW-1:0] rwaddr_i,
    output logic [REG_AW-1:0] rs1addr_o,
    output logic [REG_AW-1:0] rs2addr_o,
    input  logic [XLEN-1:0]   rs1data_i,
    input  logic [XLEN-1:0]   rs2data_i,
    output logic              redirect_o,
    output logic [XLEN-1:0]   redirect_pc_o,
    output logic              wb_en_o,
    output logic [REG_AW-1:0] wb_addr_o,
    output logic [XLEN-1:0]   wb_data_o,
    output logic [XLEN-1:0]   wb_pc_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic            rs_eq;
    logic            rs_lt;
    logic            rs_ltu;
    logic            taken;
    logic            fire;

    assign rs1addr_o = rs1addr_i;
    assign rs2addr_o = rs2addr_i;

    // instruction completes this cycle
    assign fire = valid_i && !stall_i;

    always_comb begin
        case (sel_a_i)
            SEL_A_RS1: op_a = rs1data_i;
            SEL_A_PC:  op_a = pc_i;
            default:   op_a = '0;
        endcase
        case (sel_b_i)
            SEL_B_RS2:  op_b = rs2data_i;
            SEL_B_IMM:  op_b = imm_i;
            SEL_B_FOUR: op_b = XLEN'(4);
            default:    op_b = '0;
        endcase
    end

    assign shamt = op_b[5:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // branch compare works on the register values, not the alu operands
    assign rs_eq  = (rs1data_i == rs2data_i);
    assign rs_lt  = ($signed(rs1data_i) < $signed(rs2data_i));
    assign rs_ltu = (rs1data_i < rs2data_i);

    always_comb begin
        case (br_type_i)
            BR_EQ:   taken = rs_eq;
            BR_NE:   taken = !rs_eq;
            BR_LT:   taken = rs_lt;
            BR_GE:   taken = !rs_lt;
            BR_LTU:  taken = rs_ltu;
            BR_GEU:  taken = !rs_ltu;
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = fire && taken;

    always_comb begin
        if (br_type_i == BR_JALR) begin
            redirect_pc_o = (rs1data_i + imm_i) & ~XLEN'(1);  // bit 0 cleared
        end else begin
            redirect_pc_o = pc_i + imm_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= fire && write_rd_i && (rwaddr_i != '0);  // x0 never written
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= rwaddr_i;
        wb_data_o <= alu_res;
        wb_pc_o   <= pc_i;
    end

endmodule

/* rtl/id_ex_reg.sv */
`timescale 1ns/10ps

module id_ex_reg import core_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              bubble_i,
    input  logic              flush_i,
    input  logic              valid_in_i,  // fetch side valid
    input  logic              legal_i,     // decoder valid
    input  logic [XLEN-1:0]   pc_i,
    input  alu_op_e           alu_op_i,
    input  sel_a_e            sel_a_i,
    input  sel_b_e            sel_b_i,
    input  br_type_e          br_type_i,
    input  logic              write_rd_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [REG_AW-1:0] rs1addr_i,
    input  logic [REG_AW-1:0] rs2addr_i,
    input  logic [REG_AW-1:0] rwaddr_i,
    output logic              valid_o,
    output logic [XLEN-1:0]   pc_o,
    output alu_op_e           alu_op_o,
    output sel_a_e            sel_a_o,
    output sel_b_e            sel_b_o,
    output br_type_e          br_type_o,
    output logic              write_rd_o,
    output logic [XLEN-1:0]   imm_o,
    output logic [REG_AW-1:0] rs1addr_o,
    output logic [REG_AW-1:0] rs2addr_o,
    output logic [REG_AW-1:0] rwaddr_o
);

    // clear beats hold, hold beats load
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_o    <= 1'b0;
            pc_o       <= '0;
            alu_op_o   <= ALU_ADD;
            sel_a_o    <= SEL_A_RS1;
            sel_b_o    <= SEL_B_RS2;
            br_type_o  <= BR_NONE;
            write_rd_o <= 1'b0;
            imm_o      <= '0;
            rs1addr_o  <= '0;
            rs2addr_o  <= '0;
            rwaddr_o   <= '0;
        end else if (!bubble_i) begin
            valid_o    <= valid_in_i && legal_i;
            pc_o       <= pc_i;
            alu_op_o   <= alu_op_i;
            sel_a_o    <= sel_a_i;
            sel_b_o    <= sel_b_i;
            br_type_o  <= br_type_i;
            write_rd_o <= write_rd_i;
            imm_o      <= imm_i;
            rs1addr_o  <= rs1addr_i;
            rs2addr_o  <= rs2addr_i;
            rwaddr_o   <= rwaddr_i;
        end
    end

endmodule

/* rtl/inst_decode.sv */
`timescale 1ns/10ps

module inst_decode import core_pkg::*; (
    input  logic [31:0]       instr_i,
    output logic              valid_o,
    output alu_op_e           alu_op_o,
    output sel_a_e            sel_a_o,
    output sel_b_e            sel_b_o,
    output br_type_e          br_type_o,
    output logic              write_rd_o,
    output logic [XLEN-1:0]   imm_o,
    output logic [REG_AW-1:0] rs1addr_o,
    output logic [REG_AW-1:0] rs2addr_o,
    output logic [REG_AW-1:0] rwaddr_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;

    // funct3 to alu op, alt selects sub/sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'd0:    op = alt ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = alt ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7    = instr_i[31:25];
    assign rwaddr_o  = instr_i[11:7];
    assign rs1addr_o = instr_i[19:15];
    assign rs2addr_o = instr_i[24:20];

    assign imm_i = {{52{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_j = {{44{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_b = {{52{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        valid_o    = 1'b1;
        alu_op_o   = ALU_ADD;
        sel_a_o    = SEL_A_RS1;
        sel_b_o    = SEL_B_RS2;
        br_type_o  = BR_NONE;
        write_rd_o = 1'b0;
        imm_o      = imm_i;
        case (opcode)
            OPC_OP: begin
                alu_op_o   = arith_op(funct3, instr_i[30]);
                write_rd_o = 1'b1;
                valid_o    = (funct7 == 7'h00) ||
                             (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
            end
            OPC_OP_IMM: begin
                alu_op_o   = arith_op(funct3, funct3 == 3'd5 && instr_i[30]);
                sel_b_o    = SEL_B_IMM;
                write_rd_o = 1'b1;
                if (funct3 == 3'd1) begin
                    valid_o = (instr_i[31:26] == 6'h00);
                end else if (funct3 == 3'd5) begin
                    valid_o = (instr_i[31:26] == 6'h00) || (instr_i[31:26] == 6'h10);
                end
            end
            OPC_LUI: begin
                alu_op_o   = ALU_PASS_B;
                sel_a_o    = SEL_A_ZERO;
                sel_b_o    = SEL_B_IMM;
                write_rd_o = 1'b1;
                imm_o      = imm_u;
            end
            OPC_AUIPC: begin
                sel_a_o    = SEL_A_PC;
                sel_b_o    = SEL_B_IMM;
                write_rd_o = 1'b1;
                imm_o      = imm_u;
            end
            OPC_JAL: begin
                sel_a_o    = SEL_A_PC;
                sel_b_o    = SEL_B_FOUR;  // link value pc+4
                br_type_o  = BR_JAL;
                write_rd_o = 1'b1;
                imm_o      = imm_j;
            end
            OPC_JALR: begin
                sel_a_o    = SEL_A_PC;
                sel_b_o    = SEL_B_FOUR;
                br_type_o  = BR_JALR;
                write_rd_o = 1'b1;
                valid_o    = (funct3 == 3'd0);
            end
            OPC_BRANCH: begin
                imm_o = imm_b;
                case (funct3)
                    3'd0:    br_type_o = BR_EQ;
                    3'd1:    br_type_o = BR_NE;
                    3'd4:    br_type_o = BR_LT;
                    3'd5:    br_type_o = BR_GE;
                    3'd6:    br_type_o = BR_LTU;
                    3'd7:    br_type_o = BR_GEU;
                    default: valid_o   = 1'b0;
                endcase
            end
            default: valid_o = 1'b0;  // unsupported opcode
        endcase
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/10ps

module reg_file import core_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] rs1addr_i,
    input  logic [REG_AW-1:0] rs2addr_i,
    output logic [XLEN-1:0]   rs1data_o,
    output logic [XLEN-1:0]   rs2data_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        if (rs1addr_i == '0) begin
            rs1data_o = '0;
        end else if (we_i && waddr_i == rs1addr_i) begin
            rs1data_o = wdata_i;  // bypass
        end else begin
            rs1data_o = regs[rs1addr_i];
        end
    end

    always_comb begin
        if (rs2addr_i == '0) begin
            rs2data_o = '0;
        end else if (we_i && waddr_i == rs2addr_i) begin
            rs2data_o = wdata_i;  // bypass
        end else begin
            rs2data_o = regs[rs2addr_i];
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the core_ex testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module tb_core_ex \
    -o sim_core_ex
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/sim_core_ex)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

/* verif/core_ex_assert.sv */
`timescale 1ns/10ps

module core_ex_assert import core_pkg::*; (
    input logic        clk,
    input logic        rst_i,
    input logic [31:0] instr_i,
    input logic        instr_valid_i,
    input logic        stall_i,
    input logic        redirect_o,
    input logic        wb_en_o
);

    logic writes_rd;
    logic cap_wr;

    // opcodes that write rd
    assign writes_rd = instr_i[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                            OPC_JAL, OPC_JALR};

    // fetch taken into ID/EX at this edge, nonzero rd
    assign cap_wr = instr_valid_i && !stall_i && !redirect_o && writes_rd &&
                    (instr_i[11:7] != '0);

    a_reset_quiet: assert property (@(posedge clk)
        (rst_i || $past(rst_i)) |-> (!wb_en_o && !redirect_o))
        else $error("writeback or redirect active around reset");

    a_wb_latency: assert property (@(posedge clk) disable iff (rst_i)
        ($past(cap_wr) && !stall_i) |=> wb_en_o)
        else $error("writeback missing one cycle after capture");

    a_stall_redirect: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |-> !redirect_o)
        else $error("redirect raised under stall");

    a_stall_wb: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> !wb_en_o)
        else $error("writeback after a stalled cycle");

endmodule

/* verif/tb_core_ex.sv */
`timescale 1ns/10ps

module tb_core_ex import core_pkg::*; ();

    localparam int N_ALU       = 24;
    localparam int N_CHAIN     = 12;
    localparam int N_STALL     = 12;
    localparam int N_BRANCH    = 16;
    localparam int MAX_STALL   = 3;
    localparam int LIMIT_CYC   = (8 + N_ALU + N_CHAIN + 2 * N_BRANCH
                                  + N_STALL * (MAX_STALL + 1)) * 2 + 100;

    logic              clk;
    logic              rst_i;
    logic [31:0]       instr_i;
    logic [XLEN-1:0]   pc_i;
    logic              instr_valid_i;
    logic              stall_i;
    logic              redirect_o;
    logic [XLEN-1:0]   redirect_pc_o;
    logic              wb_en_o;
    logic [REG_AW-1:0] wb_addr_o;
    logic [XLEN-1:0]   wb_data_o;
    logic [XLEN-1:0]   wb_pc_o;

    logic [31:0]       lfsr_state = 32'h48aa_baa8;
    logic [XLEN-1:0]   mirror [32];
    logic [REG_AW-1:0] exp_addr [$];
    logic [XLEN-1:0]   exp_data [$];
    logic [XLEN-1:0]   exp_pc [$];
    logic [XLEN-1:0]   cur_pc;
    logic              exp_redir;
    logic [XLEN-1:0]   exp_target;
    int                errors;
    int                checks;

    core_ex_top DUT (.*);

    bind core_ex_top core_ex_assert u_assert (
        .clk(clk), .rst_i(rst_i), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
        .stall_i(stall_i), .redirect_o(redirect_o), .wb_en_o(wb_en_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32,22,2,1
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[5:0];
            3'd2:    r = {63'd0, $signed(a) < $signed(b)};
            3'd3:    r = {63'd0, a < b};
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? $signed(a) >>> b[5:0] : a >> b[5:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // ISA reference for one instruction against the register mirror
    function automatic void model_exec(input logic [31:0] ins, input logic [63:0] pc,
                                       output logic wr, output logic [4:0] rd,
                                       output logic [63:0] val, output logic taken,
                                       output logic [63:0] target);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_u;
        logic [2:0]  f3;
        f3     = ins[14:12];
        rd     = ins[11:7];
        a      = mirror[ins[19:15]];
        b      = mirror[ins[24:20]];
        imm_i  = {{52{ins[31]}}, ins[31:20]};
        imm_u  = {{32{ins[31]}}, ins[31:12], 12'b0};
        wr     = 1'b1;
        taken  = 1'b0;
        val    = '0;
        target = '0;
        case (ins[6:0])
            7'h13: val = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
            7'h33: val = alu_ref(f3, ins[30], a, b);
            7'h37: val = imm_u;
            7'h17: val = pc + imm_u;
            7'h6f: begin
                val    = pc + 4;
                taken  = 1'b1;
                target = pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                val    = pc + 4;
                taken  = 1'b1;
                target = (a + imm_i) & ~64'd1;
            end
            default: begin  // conditional branch
                wr = 1'b0;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                target = pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        endcase
    endfunction

    function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1);
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rs2;
        f3  = 3'(rnd(3));
        imm = 12'(rnd(12));
        rs2 = 5'(rnd(3));
        case (2'(rnd(2)))
            2'd0: begin
                if (f3 == 3'd1) imm[11:6] = 6'h00;
                if (f3 == 3'd5) imm[11:6] = imm[11] ? 6'h10 : 6'h00;
                return {imm, rs1, f3, rd, 7'h13};
            end
            2'd1: return {20'(rnd(20)), rd, 7'h37};
            2'd2: return {20'(rnd(20)), rd, 7'h17};
            default: return {(f3 == 3'd0 || f3 == 3'd5) && imm[0] ? 7'h20 : 7'h00,
                             rs2, rs1, f3, rd, 7'h33};
        endcase
    endfunction

    // present one instruction until captured and check the previous redirect
    task automatic issue(input logic [31:0] ins, input logic vld, input int stall_n);
        logic            wr;
        logic [4:0]      rd;
        logic [63:0]     val;
        logic            taken;
        logic [63:0]     target;
        instr_i       = ins;
        pc_i          = cur_pc;
        instr_valid_i = vld;
        stall_i       = (stall_n > 0);
        repeat (stall_n) @(posedge clk);
        #1 stall_i = 1'b0;
        @(negedge clk);
        checks++;
        assert (redirect_o == exp_redir && (!exp_redir || redirect_pc_o == exp_target))
        else begin
            $display("[FAIL] %0t redirect %0b pc %h, expected %0b pc %h", $time,
                     redirect_o, redirect_pc_o, exp_redir, exp_target);
            errors++;
        end
        if (exp_redir) begin
            exp_redir = 1'b0;
            cur_pc    = exp_target;  // this fetch is dropped
        end else if (vld) begin
            model_exec(ins, cur_pc, wr, rd, val, taken, target);
            if (wr && rd != 0) begin
                mirror[rd] = val;
                exp_addr.push_back(rd);
                exp_data.push_back(val);
                exp_pc.push_back(cur_pc);
            end
            exp_redir  = taken;
            exp_target = target;
            cur_pc     = cur_pc + 4;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report(input string name, input int n, input int err0);
        $display("%s: %0d instructions, %0d errors", name, n, errors - err0);
    endtask

    // writeback monitor
    always @(negedge clk) begin
        if (!rst_i && wb_en_o) begin
            checks++;
            if (exp_addr.size() == 0) begin
                $display("[FAIL] %0t unexpected writeback pc %h", $time, wb_pc_o);
                errors++;
            end else begin
                assert (wb_addr_o == exp_addr[0] && wb_data_o == exp_data[0] &&
                        wb_pc_o == exp_pc[0])
                else begin
                    $display("[FAIL] %0t wb x%0d=%h pc %h, expected x%0d=%h pc %h", $time,
                             wb_addr_o, wb_data_o, wb_pc_o, exp_addr[0], exp_data[0],
                             exp_pc[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_pc.pop_front());
            end
        end
    end

    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles", LIMIT_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        int         err0;
        logic [4:0] prev_rd;
        logic [4:0] rd;
        logic [2:0] f3;
        instr_i       = '0;
        pc_i          = '0;
        instr_valid_i = 1'b0;
        stall_i       = 1'b0;
        rst_i         = 1'b1;
        cur_pc        = 64'h1000;
        exp_redir     = 1'b0;
        exp_target    = '0;
        errors        = 0;
        checks        = 0;
        for (int i = 0; i < 32; i++) mirror[i] = '0;
        repeat (4) @(posedge clk);
        #1 rst_i = 1'b0;
        $display("reset quiet: done");

        err0 = errors;
        for (int r = 1; r < 8; r++) begin
            issue({12'(rnd(12)), 5'd0, 3'd0, 5'(r), 7'h13}, 1'b1, 0);  // seed x1..x7
        end
        for (int i = 0; i < N_ALU; i++) issue(rand_alu(5'(rnd(3)), 5'(rnd(3))), 1'b1, 0);
        report("alu ops", N_ALU + 7, err0);

        err0    = errors;
        prev_rd = 5'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 5'(rnd(3) % 7 + 1);
            if (rnd(1)) issue({12'(rnd(12)), prev_rd, 3'd0, rd, 7'h13}, 1'b1, 0);
            else issue({7'h00, prev_rd, prev_rd, 3'd0, rd, 7'h33}, 1'b1, 0);
            prev_rd = rd;
        end
        report("dependent chains", N_CHAIN, err0);

        err0 = errors;
        for (int i = 0; i < N_STALL; i++) begin
            issue(rand_alu(5'(rnd(3)), 5'(rnd(3))), 1'b1, int'(rnd(2)));
        end
        report("stall", N_STALL, err0);

        err0 = errors;
        for (int i = 0; i < N_BRANCH; i++) begin
            f3 = 3'(rnd(3));
            if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
            case (2'(rnd(2)))
                2'd0: issue({20'(rnd(20)), 5'(rnd(3)), 7'h6f} & 32'hffe0_0fff |
                            {20'd0, 5'(rnd(3)), 7'd0}, 1'b1, 0);
                2'd1: issue({12'(rnd(12)), 5'(rnd(3)), 3'd0, 5'(rnd(3)), 7'h67}, 1'b1, 0);
                default: issue({7'(rnd(7)), 5'(rnd(3)), 5'(rnd(3)), f3, 5'(rnd(5)), 7'h63},
                               1'b1, int'(rnd(1)));
            endcase
            issue(rand_alu(5'(rnd(3)), 5'(rnd(3))), 1'b1, int'(rnd(1)));
        end
        report("branches and jumps", 2 * N_BRANCH, err0);

        issue('0, 1'b0, 0);
        issue('0, 1'b0, 0);
        for (int i = 0; i < 10 && exp_addr.size() != 0; i++) @(posedge clk);
        if (exp_addr.size() != 0) begin
            $display("%0d expected writebacks never arrived", exp_addr.size());
            errors++;
        end

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
